// ==== hdl/rtc_pkg.sv ====
/*
 * Shared types and constants of the real-time clock. Every RTL block pulls
 * what it needs from here, so register indexes and field layouts agree.
 */
package rtc_pkg;

    localparam int tick_hz          = 800;  // Base tick rate
    localparam int ticks_per_second = 800;
    localparam int start_ticks      = 4;    // Ticks to the first second after start

    // Highest value of each field before it wraps
    localparam logic [7:0] max_second      = 8'd59;
    localparam logic [7:0] max_minute      = 8'd59;
    localparam logic [7:0] max_hour        = 8'd23;
    localparam logic [7:0] max_day_of_week = 8'd7;
    localparam logic [7:0] max_month       = 8'd12;
    localparam logic [7:0] max_year        = 8'd99;

    // Days per month, December down to January
    localparam logic [12:1][7:0] month_days = {
        8'd31, 8'd30, 8'd31, 8'd30, 8'd31, 8'd31,
        8'd30, 8'd31, 8'd30, 8'd31, 8'd28, 8'd31
    };

    typedef enum logic [6:0] {
        REG_SECOND       = 7'h00,
        REG_ALARM_SECOND = 7'h01,
        REG_MINUTE       = 7'h02,
        REG_ALARM_MINUTE = 7'h03,
        REG_HOUR         = 7'h04,
        REG_ALARM_HOUR   = 7'h05,
        REG_DAY_OF_WEEK  = 7'h06,
        REG_DAY_OF_MONTH = 7'h07,
        REG_MONTH        = 7'h08,
        REG_YEAR         = 7'h09,
        REG_STATUS_A     = 7'h0A,
        REG_STATUS_B     = 7'h0B,
        REG_STATUS_C     = 7'h0C,
        REG_STATUS_D     = 7'h0D
    } rtc_reg_e;

    typedef enum logic [2:0] {
        SEC_UPDATE_START,
        SEC_UPDATE_IN_PROGRESS,
        SEC_SECOND_START,
        SEC_SECOND_IN_PROGRESS,
        SEC_STOPPED
    } sec_state_e;

    typedef enum logic [2:0] {
        FIELD_SECOND,
        FIELD_MINUTE,
        FIELD_HOUR,
        FIELD_DAY_OF_WEEK,
        FIELD_DAY_OF_MONTH,
        FIELD_MONTH,
        FIELD_YEAR
    } rtc_field_e;

    typedef struct packed {
        logic [7:0] second;
        logic [7:0] minute;
        logic [7:0] hour;
        logic [7:0] day_of_week;
        logic [7:0] day_of_month;
        logic [7:0] month;
        logic [7:0] year;
    } rtc_time_t;

    typedef struct packed {
        logic       read;   // Single-cycle strobe
        logic       write;  // Single-cycle strobe
        logic       addr;   // 0 index port, 1 data port
        logic [7:0] wdata;
    } rtc_bus_req_t;

    typedef struct packed {
        logic       valid;
        rtc_field_e field;
        logic [7:0] data;
    } rtc_time_wr_t;

    typedef struct packed {
        logic freeze;
        logic alarm_ena;
        logic update_ena;
    } rtc_ctrl_t;

endpackage

// ==== hdl/rtc_tick_gen.sv ====
/*
 * Fractional rate divider. Turns the system clock into an 800 Hz strobe
 * whose spacing varies by one cycle when clock_hz is not a multiple of it.
 */
module rtc_tick_gen #(
    parameter int unsigned clock_hz = 50_000_000
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);
    import rtc_pkg::*;

    localparam int acc_w = $clog2(clock_hz + tick_hz) + 1;

    logic [acc_w-1:0] acc;
    logic [acc_w-1:0] sum;

    assign sum = acc + acc_w'(tick_hz);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc  <= '0;
            tick <= 1'b0;
        end else if (sum >= acc_w'(clock_hz)) begin
            acc  <= sum - acc_w'(clock_hz);  // Keep the remainder
            tick <= 1'b1;
        end else begin
            acc  <= sum;
            tick <= 1'b0;
        end
    end

endmodule

// ==== hdl/rtc_second_seq.sv ====
/*
 * Once-per-second sequencer. Counts 800 Hz ticks, raises update-in-progress
 * ahead of each second and strobes second_start. Freeze holds it stopped.
 */
module rtc_second_seq (
    input  logic clk,
    input  logic rst_n,
    input  logic tick,
    input  logic freeze,
    output logic second_start,
    output logic uip
);
    import rtc_pkg::*;

    sec_state_e  state;
    logic [10:0] countdown;

    // Zero lasts until the next tick, which reloads a full second
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            countdown <= 11'(start_ticks);
        end else if (freeze) begin
            countdown <= 11'(start_ticks);
        end else if (tick) begin
            countdown <= (countdown == '0) ? 11'(ticks_per_second - 1) : countdown - 11'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SEC_UPDATE_START;
        end else if (freeze) begin
            state <= SEC_STOPPED;
        end else begin
            case (state)
                SEC_STOPPED:            state <= SEC_UPDATE_START;
                SEC_UPDATE_START:
                    state <= (countdown == '0) ? SEC_SECOND_START : SEC_UPDATE_IN_PROGRESS;
                SEC_UPDATE_IN_PROGRESS: if (countdown == '0) state <= SEC_SECOND_START;
                SEC_SECOND_START:       state <= SEC_SECOND_IN_PROGRESS;
                SEC_SECOND_IN_PROGRESS: if (countdown == 11'd1) state <= SEC_UPDATE_START;
                default:                state <= SEC_UPDATE_START;
            endcase
        end
    end

    assign second_start = (state == SEC_SECOND_START);
    assign uip          = (state == SEC_UPDATE_IN_PROGRESS) || (state == SEC_SECOND_START);

endmodule

// ==== hdl/rtc_calendar.sv ====
/*
 * Binary 24-hour time and date counters. Each second_start advances the
 * seconds and ripples carries up to the year; host field writes take priority.
 */
module rtc_calendar (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 second_start,
    input  rtc_pkg::rtc_time_wr_t time_wr,
    output rtc_pkg::rtc_time_t   cur_time,
    output logic                 second_done
);
    import rtc_pkg::*;

    rtc_time_t  nxt;
    logic [7:0] days_in_month;
    logic       leap_year;
    logic       sec_wrap;
    logic       min_wrap;
    logic       hour_wrap;
    logic       dom_wrap;
    logic       month_wrap;

    assign leap_year = (cur_time.year[1:0] == 2'b00);  // Good for years 00 to 99

    always_comb begin
        if (cur_time.month == 8'd2 && leap_year) begin
            days_in_month = 8'd29;
        end else if (cur_time.month >= 8'd1 && cur_time.month <= max_month) begin
            days_in_month = month_days[cur_time.month[3:0]];
        end else begin
            days_in_month = 8'd31;  // Out-of-range month
        end
    end

    assign sec_wrap   = (cur_time.second >= max_second);
    assign min_wrap   = (cur_time.minute >= max_minute);
    assign hour_wrap  = (cur_time.hour >= max_hour);
    assign dom_wrap   = (cur_time.day_of_month >= days_in_month);
    assign month_wrap = (cur_time.month >= max_month);

    always_comb begin
        nxt = cur_time;
        if (second_start) begin
            nxt.second = sec_wrap ? 8'd0 : cur_time.second + 8'd1;
            if (sec_wrap) begin
                nxt.minute = min_wrap ? 8'd0 : cur_time.minute + 8'd1;
                if (min_wrap) begin
                    nxt.hour = hour_wrap ? 8'd0 : cur_time.hour + 8'd1;
                    if (hour_wrap) begin
                        // Day carry
                        nxt.day_of_week = (cur_time.day_of_week >= max_day_of_week) ?
                                          8'd1 : cur_time.day_of_week + 8'd1;
                        nxt.day_of_month = dom_wrap ? 8'd1 : cur_time.day_of_month + 8'd1;
                        if (dom_wrap) begin
                            nxt.month = month_wrap ? 8'd1 : cur_time.month + 8'd1;
                            if (month_wrap) begin
                                nxt.year = (cur_time.year >= max_year) ?
                                           8'd0 : cur_time.year + 8'd1;
                            end
                        end
                    end
                end
            end
        end

        // Host write replaces one field only
        if (time_wr.valid) begin
            case (time_wr.field)
                FIELD_SECOND:       nxt.second       = time_wr.data;
                FIELD_MINUTE:       nxt.minute       = time_wr.data;
                FIELD_HOUR:         nxt.hour         = time_wr.data;
                FIELD_DAY_OF_WEEK:  nxt.day_of_week  = time_wr.data;
                FIELD_DAY_OF_MONTH: nxt.day_of_month = time_wr.data;
                FIELD_MONTH:        nxt.month        = time_wr.data;
                FIELD_YEAR:         nxt.year         = time_wr.data;
                default:            ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_time    <= '0;
            second_done <= 1'b0;
        end else begin
            cur_time    <= nxt;
            second_done <= second_start;  // Same cycle as the new time
        end
    end

endmodule

// ==== hdl/rtc_regs.sv ====
/*
 * Host register file behind the index/data port pair. Holds the index,
 * alarm and control bytes and the interrupt flags, and drives irq.
 */
module rtc_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rtc_pkg::rtc_bus_req_t bus,
    input  logic                  uip,
    input  rtc_pkg::rtc_time_t    cur_time,
    input  logic                  second_done,
    output rtc_pkg::rtc_time_wr_t time_wr,
    output rtc_pkg::rtc_ctrl_t    ctrl,
    output logic [7:0]            io_readdata,
    output logic                  irq
);
    import rtc_pkg::*;

    logic [6:0] index;
    logic [7:0] alarm_second;
    logic [7:0] alarm_minute;
    logic [7:0] alarm_hour;
    logic       update_flag;
    logic       alarm_flag;
    logic       data_wr;
    logic       status_c_rd;
    logic       alarm_match;
    logic       wr_is_time;
    rtc_field_e wr_field;
    logic [7:0] read_mux;

    assign data_wr     = bus.write && bus.addr;
    assign status_c_rd = bus.read && bus.addr && (index == REG_STATUS_C);

    // Alarm bytes of 0xC0 and up match anything
    assign alarm_match = (alarm_second[7:6] == 2'b11 || alarm_second == cur_time.second) &&
                         (alarm_minute[7:6] == 2'b11 || alarm_minute == cur_time.minute) &&
                         (alarm_hour[7:6] == 2'b11 || alarm_hour == cur_time.hour);

    always_comb begin
        wr_is_time = 1'b1;
        wr_field   = FIELD_SECOND;
        case (index)
            REG_SECOND:       wr_field = FIELD_SECOND;
            REG_MINUTE:       wr_field = FIELD_MINUTE;
            REG_HOUR:         wr_field = FIELD_HOUR;
            REG_DAY_OF_WEEK:  wr_field = FIELD_DAY_OF_WEEK;
            REG_DAY_OF_MONTH: wr_field = FIELD_DAY_OF_MONTH;
            REG_MONTH:        wr_field = FIELD_MONTH;
            REG_YEAR:         wr_field = FIELD_YEAR;
            default:          wr_is_time = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index        <= '0;
            time_wr      <= '0;
            ctrl         <= '0;
            alarm_second <= '0;
            alarm_minute <= '0;
            alarm_hour   <= '0;
        end else begin
            if (bus.write && !bus.addr) index <= bus.wdata[6:0];
            time_wr.valid <= data_wr && wr_is_time;  // Calendar applies it next edge
            time_wr.field <= wr_field;
            time_wr.data  <= bus.wdata;
            if (data_wr) begin
                case (index)
                    REG_ALARM_SECOND: alarm_second <= bus.wdata;
                    REG_ALARM_MINUTE: alarm_minute <= bus.wdata;
                    REG_ALARM_HOUR:   alarm_hour   <= bus.wdata;
                    REG_STATUS_B: begin
                        ctrl.freeze     <= bus.wdata[7];
                        ctrl.alarm_ena  <= bus.wdata[5];
                        ctrl.update_ena <= bus.wdata[4] & ~bus.wdata[7];  // No update irq when frozen
                    end
                    default: ;
                endcase
            end
        end
    end

    // A new second outranks a status C read on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            update_flag <= 1'b0;
            alarm_flag  <= 1'b0;
            irq         <= 1'b0;
        end else begin
            if (second_done) update_flag <= 1'b1;
            else if (status_c_rd) update_flag <= 1'b0;
            if (second_done && alarm_match) alarm_flag <= 1'b1;
            else if (status_c_rd) alarm_flag <= 1'b0;
            if (status_c_rd) begin
                irq <= 1'b0;
            end else if ((alarm_flag && ctrl.alarm_ena) || (update_flag && ctrl.update_ena)) begin
                irq <= 1'b1;
            end
        end
    end

    always_comb begin
        if (!bus.addr) begin
            read_mux = 8'hFF;  // Index port is write-only
        end else begin
            case (index)
                REG_SECOND:       read_mux = cur_time.second;
                REG_ALARM_SECOND: read_mux = alarm_second;
                REG_MINUTE:       read_mux = cur_time.minute;
                REG_ALARM_MINUTE: read_mux = alarm_minute;
                REG_HOUR:         read_mux = cur_time.hour;
                REG_ALARM_HOUR:   read_mux = alarm_hour;
                REG_DAY_OF_WEEK:  read_mux = cur_time.day_of_week;
                REG_DAY_OF_MONTH: read_mux = cur_time.day_of_month;
                REG_MONTH:        read_mux = cur_time.month;
                REG_YEAR:         read_mux = cur_time.year;
                REG_STATUS_A:     read_mux = {uip, 3'b010, 4'b0000};
                REG_STATUS_B:     read_mux = {ctrl.freeze, 1'b0, ctrl.alarm_ena,
                                              ctrl.update_ena, 4'b0110};  // Binary, 24 hour
                REG_STATUS_C:     read_mux = {irq, 1'b0, alarm_flag, update_flag, 4'b0000};
                REG_STATUS_D:     read_mux = 8'h80;  // Battery good
                default:          read_mux = 8'h00;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bus.read) io_readdata <= read_mux;  // Held until the next read
    end

endmodule

// ==== hdl/rtc_top.sv ====
/*
 * Real-time clock top level. Connects the tick generator, the second
 * sequencer, the calendar and the host registers; clock_hz sets the input rate.
 */
module rtc_top #(
    parameter int unsigned clock_hz = 50_000_000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rtc_pkg::rtc_bus_req_t bus,
    output logic [7:0]            io_readdata,
    output logic                  irq
);
    import rtc_pkg::*;

    logic          tick;
    logic          second_start;
    logic          uip;
    logic          second_done;
    rtc_ctrl_t     ctrl;
    rtc_time_wr_t  time_wr;
    rtc_time_t     cur_time;

    rtc_tick_gen #(
        .clock_hz (clock_hz)
    ) u_tick_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    rtc_second_seq u_second_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .tick         (tick),
        .freeze       (ctrl.freeze),
        .second_start (second_start),
        .uip          (uip)
    );

    rtc_calendar u_calendar (
        .clk          (clk),
        .rst_n        (rst_n),
        .second_start (second_start),
        .time_wr      (time_wr),
        .cur_time     (cur_time),
        .second_done  (second_done)
    );

    rtc_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (bus),
        .uip         (uip),
        .cur_time    (cur_time),
        .second_done (second_done),
        .time_wr     (time_wr),
        .ctrl        (ctrl),
        .io_readdata (io_readdata),
        .irq         (irq)
    );

endmodule

// ==== test/rtc_properties.sv ====
/*
 * Concurrent checks on the RTC top level, attached by bind.
 * Watches irq causes, the second strobe width and irq clearing.
 */
module rtc_properties (
    input logic               clk,
    input logic               rst_n,
    input logic               irq,
    input logic               second_start,
    input logic               alarm_flag,
    input logic               update_flag,
    input rtc_pkg::rtc_ctrl_t ctrl,
    input logic               status_c_rd
);
    timeunit 1ns;
    timeprecision 100ps;

    int error_count = 0;

    irq_has_cause: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(irq) |-> $past((alarm_flag && ctrl.alarm_ena) || (update_flag && ctrl.update_ena)))
    else begin
        $error("irq rose without an enabled interrupt flag");
        error_count++;
    end

    second_start_single: assert property (@(posedge clk) disable iff (!rst_n)
        second_start |=> !second_start)
    else begin
        $error("second_start lasted more than one cycle");
        error_count++;
    end

    // Status C read is the only way out for irq
    irq_falls_on_read: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(irq) |-> $past(status_c_rd))
    else begin
        $error("irq fell without a status C read");
        error_count++;
    end

endmodule

bind rtc_top rtc_properties props0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .irq          (irq),
    .second_start (second_start),
    .alarm_flag   (u_regs.alarm_flag),
    .update_flag  (u_regs.update_flag),
    .ctrl         (ctrl),
    .status_c_rd  (u_regs.status_c_rd)
);

// ==== test/rtc_tb.sv ====
/*
 * Testbench for the real-time clock. Drives the index/data port pair and checks
 * reset values, register read-back, counting, rollovers, the alarm irq and freeze.
 */
module rtc_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rtc_pkg::*;

    localparam int unsigned clock_hz = 1600;
    localparam int cycles_per_second = 1600;  // One second of clk cycles

    logic         clk;
    logic         rst_n;
    rtc_bus_req_t bus;
    logic [7:0]   io_readdata;
    logic         irq;
    logic [31:0]  lfsr_state;
    string        name_q[$];
    logic [7:0]   exp_q[$];
    logic [7:0]   act_q[$];

    rtc_top #(
        .clock_hz (clock_hz)
    ) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (bus),
        .io_readdata (io_readdata),
        .irq         (irq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic void queue_check(input string name, input logic [7:0] expected,
                                        input logic [7:0] actual);
        name_q.push_back(name);
        exp_q.push_back(expected);
        act_q.push_back(actual);
    endfunction

    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] random_bits(input int count);
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[14:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return bits;
    endfunction

    function automatic int month_length(input logic [7:0] month, input logic [7:0] year);
        case (month)
            8'd2:                    return (year % 4 == 0) ? 29 : 28;
            8'd4, 8'd6, 8'd9, 8'd11: return 30;
            default:                 return 31;
        endcase
    endfunction

    // Reference successor of a time, binary 24-hour calendar
    function automatic rtc_time_t next_time(input rtc_time_t t);
        rtc_time_t n;
        n = t;
        n.second = t.second + 8'd1;
        if (n.second == 8'd60) begin
            n.second = 8'd0;
            n.minute = t.minute + 8'd1;
            if (n.minute == 8'd60) begin
                n.minute = 8'd0;
                n.hour   = t.hour + 8'd1;
                if (n.hour == 8'd24) begin
                    n.hour         = 8'd0;
                    n.day_of_week  = (t.day_of_week == 8'd7) ? 8'd1 : t.day_of_week + 8'd1;
                    n.day_of_month = t.day_of_month + 8'd1;
                    if (n.day_of_month > month_length(t.month, t.year)) begin
                        n.day_of_month = 8'd1;
                        n.month        = t.month + 8'd1;
                        if (n.month == 8'd13) begin
                            n.month = 8'd1;
                            n.year  = (t.year == 8'd99) ? 8'd0 : t.year + 8'd1;
                        end
                    end
                end
            end
        end
        return n;
    endfunction

    function automatic rtc_time_t random_time();
        rtc_time_t t;
        t.second       = 8'(random_bits(16) % 60);
        t.minute       = 8'(random_bits(16) % 60);
        t.hour         = 8'(random_bits(16) % 24);
        t.day_of_week  = 8'(1 + random_bits(16) % 7);
        t.year         = 8'(random_bits(16) % 100);
        t.month        = 8'(1 + random_bits(16) % 12);
        t.day_of_month = 8'(1 + random_bits(16) % month_length(t.month, t.year));
        return t;
    endfunction

    task automatic write_index(input logic [6:0] idx);
        @(posedge clk);
        #1;
        bus.write = 1'b1;
        bus.addr  = 1'b0;
        bus.wdata = {1'b0, idx};
        @(posedge clk);
        #1;
        bus = '0;
    endtask

    task automatic write_data(input logic [7:0] data);
        @(posedge clk);
        #1;
        bus.write = 1'b1;
        bus.addr  = 1'b1;
        bus.wdata = data;
        @(posedge clk);
        #1;
        bus = '0;
    endtask

    task automatic read_data(input logic port, output logic [7:0] data);
        @(posedge clk);
        #1;
        bus.read = 1'b1;
        bus.addr = port;
        @(posedge clk);
        #1;
        bus  = '0;
        data = io_readdata;  // Registered on the edge just passed
    endtask

    task automatic write_reg(input logic [6:0] idx, input logic [7:0] data);
        write_index(idx);
        write_data(data);
    endtask

    task automatic read_reg(input logic [6:0] idx, output logic [7:0] data);
        write_index(idx);
        read_data(1'b1, data);
    endtask

    task automatic check_reg(input string name, input logic [6:0] idx,
                             input logic [7:0] expected);
        logic [7:0] value;
        read_reg(idx, value);
        queue_check(name, expected, value);
    endtask

    task automatic write_time(input rtc_time_t t);
        write_reg(REG_SECOND, t.second);
        write_reg(REG_MINUTE, t.minute);
        write_reg(REG_HOUR, t.hour);
        write_reg(REG_DAY_OF_WEEK, t.day_of_week);
        write_reg(REG_DAY_OF_MONTH, t.day_of_month);
        write_reg(REG_MONTH, t.month);
        write_reg(REG_YEAR, t.year);
    endtask

    task automatic read_time(output rtc_time_t t);
        read_reg(REG_SECOND, t.second);
        read_reg(REG_MINUTE, t.minute);
        read_reg(REG_HOUR, t.hour);
        read_reg(REG_DAY_OF_WEEK, t.day_of_week);
        read_reg(REG_DAY_OF_MONTH, t.day_of_month);
        read_reg(REG_MONTH, t.month);
        read_reg(REG_YEAR, t.year);
    endtask

    task automatic compare_time(input string name, input rtc_time_t expected,
                                input rtc_time_t actual);
        queue_check({name, " second"}, expected.second, actual.second);
        queue_check({name, " minute"}, expected.minute, actual.minute);
        queue_check({name, " hour"}, expected.hour, actual.hour);
        queue_check({name, " day of week"}, expected.day_of_week, actual.day_of_week);
        queue_check({name, " day of month"}, expected.day_of_month, actual.day_of_month);
        queue_check({name, " month"}, expected.month, actual.month);
        queue_check({name, " year"}, expected.year, actual.year);
    endtask

    task automatic clear_status_c();
        logic [7:0] value;
        read_reg(REG_STATUS_C, value);
    endtask

    task automatic wait_update_flag();
        logic [7:0] status;
        int         waited;
        status = 8'h00;
        waited = 0;
        write_index(REG_STATUS_C);
        while (!status[4]) begin
            if (waited > 2 * cycles_per_second) begin
                report_failure("Timed out waiting for the update flag in status C");
            end
            read_data(1'b1, status);
            waited += 2;
        end
    endtask

    task automatic wait_irq();
        int waited;
        waited = 0;
        while (irq !== 1'b1) begin
            if (waited > 2 * cycles_per_second) begin
                report_failure("Timed out waiting for irq to rise");
            end
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    // Freeze, load a time, release and compare after the first second
    task automatic run_one_second(input string name, input rtc_time_t start,
                                  input rtc_time_t expected);
        rtc_time_t got;
        write_reg(REG_STATUS_B, 8'h80);
        write_time(start);
        clear_status_c();
        write_reg(REG_STATUS_B, 8'h00);  // First second follows a few ticks later
        wait_update_flag();
        read_time(got);
        compare_time(name, expected, got);
    endtask

    always @(posedge clk) begin : compare_results
        string      name;
        logic [7:0] expected;
        logic [7:0] actual;
        while (act_q.size() != 0) begin
            name     = name_q.pop_front();
            expected = exp_q.pop_front();
            actual   = act_q.pop_front();
            assert (actual === expected)
            else report_failure($sformatf("[FAIL] %s: expected 0x%02h, actual 0x%02h",
                                          name, expected, actual));
        end
    end

    initial begin : main
        rtc_time_t  t;
        rtc_time_t  expected;
        logic [7:0] value;
        logic [7:0] written [0:9];
        int         waited;
        lfsr_state = 32'he077;
        bus        = '0;
        rst_n      = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Index is 0 after reset; second and status C go before the first second lands
        read_data(1'b1, value);
        queue_check("reset second", 8'h00, value);
        check_reg("reset status C", REG_STATUS_C, 8'h00);
        queue_check("reset irq", 8'h00, {7'b0, irq});
        check_reg("reset minute", REG_MINUTE, 8'h00);
        check_reg("reset hour", REG_HOUR, 8'h00);
        check_reg("reset day of week", REG_DAY_OF_WEEK, 8'h00);
        check_reg("reset day of month", REG_DAY_OF_MONTH, 8'h00);
        check_reg("reset month", REG_MONTH, 8'h00);
        check_reg("reset year", REG_YEAR, 8'h00);
        check_reg("reset status B", REG_STATUS_B, 8'h06);
        check_reg("reset status D", REG_STATUS_D, 8'h80);
        read_data(1'b0, value);
        queue_check("index port", 8'hFF, value);

        write_reg(REG_STATUS_B, 8'h80);
        for (int i = 0; i < 10; i++) begin
            written[i] = 8'(random_bits(8));
            write_reg(7'(i), written[i]);
        end
        for (int i = 0; i < 10; i++) begin
            read_reg(7'(i), value);
            queue_check($sformatf("read-back index %0d", i), written[i], value);
        end

        repeat (4) begin
            t = random_time();
            run_one_second("count", t, next_time(t));
        end

        // Fields in order second, minute, hour, day of week, day of month, month, year
        run_one_second("year end", {8'd59, 8'd59, 8'd23, 8'd7, 8'd31, 8'd12, 8'd99},
                       {8'd0, 8'd0, 8'd0, 8'd1, 8'd1, 8'd1, 8'd0});
        run_one_second("leap day", {8'd59, 8'd59, 8'd23, 8'd3, 8'd28, 8'd2, 8'd24},
                       {8'd0, 8'd0, 8'd0, 8'd4, 8'd29, 8'd2, 8'd24});
        run_one_second("no leap", {8'd59, 8'd59, 8'd23, 8'd3, 8'd28, 8'd2, 8'd23},
                       {8'd0, 8'd0, 8'd0, 8'd4, 8'd1, 8'd3, 8'd23});

        t        = random_time();
        expected = next_time(t);
        write_reg(REG_STATUS_B, 8'h80);
        write_time(t);
        write_reg(REG_ALARM_SECOND, expected.second);
        write_reg(REG_ALARM_MINUTE, 8'hC0);  // Any minute
        write_reg(REG_ALARM_HOUR, 8'hC0);
        clear_status_c();
        queue_check("irq before alarm", 8'h00, {7'b0, irq});
        write_reg(REG_STATUS_B, 8'h20);
        wait_irq();
        check_reg("alarm status C", REG_STATUS_C, 8'hB0);
        read_data(1'b1, value);
        queue_check("status C after clear", 8'h00, value);
        queue_check("irq after clear", 8'h00, {7'b0, irq});

        write_reg(REG_STATUS_B, 8'h90);
        check_reg("freeze status B", REG_STATUS_B, 8'h86);
        t = random_time();
        write_time(t);
        clear_status_c();
        repeat (3 * cycles_per_second) @(posedge clk);
        #1;
        read_time(expected);
        compare_time("frozen", t, expected);
        check_reg("frozen status C", REG_STATUS_C, 8'h00);
        check_reg("frozen status A", REG_STATUS_A, 8'h20);  // Stopped, no update in progress

        waited = 0;
        while (act_q.size() != 0 && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        #1;
        if (act_q.size() != 0) begin
            report_failure("Some checks were never compared");
        end else if (dut0.props0.error_count != 0) begin
            report_failure("A concurrent assertion on the DUT failed");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
hdl/rtc_pkg.sv
hdl/rtc_tick_gen.sv
hdl/rtc_second_seq.sv
hdl/rtc_calendar.sv
hdl/rtc_regs.sv
hdl/rtc_top.sv
test/rtc_properties.sv
test/rtc_tb.sv

// ==== Bender.yml ====
package:
  name: rtc

sources:
  - files:
      - hdl/rtc_pkg.sv
      - hdl/rtc_tick_gen.sv
      - hdl/rtc_second_seq.sv
      - hdl/rtc_calendar.sv
      - hdl/rtc_regs.sv
      - hdl/rtc_top.sv
  - target: test
    files:
      - test/rtc_properties.sv
      - test/rtc_tb.sv
